//--- rmt_pipeline.f
source/rmt_pkg.sv
source/sync_fifo.sv
source/pkt_filter.sv
source/phv_parser.sv
source/match_action_stage.sv
source/phv_deparser.sv
source/rmt_pipeline.sv
sim/rmt_pipeline_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module rmt_pipeline_tb -f rmt_pipeline.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vrmt_pipeline_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
	exit 0
fi
exit 1

//--- sim/rmt_pipeline_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rmt_pipeline_tb;
	import rmt_pkg::*;

	localparam int CLK_PERIOD = 40;

	logic clk;
	logic aresetn;
	logic [31:0] vlan_drop_flags;
	logic [31:0] ctrl_token;
	logic [DATA_W-1:0] s_axis_tdata;
	logic [KEEP_W-1:0] s_axis_tkeep;
	logic s_axis_tvalid;
	logic s_axis_tready;
	logic s_axis_tlast;
	logic [DATA_W-1:0] m_axis_tdata;
	logic [KEEP_W-1:0] m_axis_tkeep;
	logic m_axis_tvalid;
	logic m_axis_tready;
	logic m_axis_tlast;

	// reference tables, one row per stage
	logic [1:0] ref_op [0:3][0:15];
	logic [1:0] ref_dst [0:3][0:15];
	logic [15:0] ref_operand [0:3][0:15];

	logic [DATA_W-1:0] exp_data [$];
	logic [KEEP_W-1:0] exp_keep [$];
	logic exp_last [$];
	int out_count = 0; // beats already matched by the monitor
	logic [31:0] exp_token;
	int ready_mode = 0; // 0 always ready, 1 random, 2 held low
	int beats_sent = 0;
	int value_errors = 0;
	int unexpected_beats = 0;
	int stall_errors = 0;
	int check_errors = 0;

	rmt_pipeline UUT (
		.clk(clk),
		.aresetn(aresetn),
		.vlan_drop_flags(vlan_drop_flags),
		.ctrl_token(ctrl_token),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tkeep(s_axis_tkeep),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tready(s_axis_tready),
		.s_axis_tlast(s_axis_tlast),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tkeep(m_axis_tkeep),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready),
		.m_axis_tlast(m_axis_tlast)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// stages in order, each one edits at most one field
	function automatic logic [DATA_W-1:0] expect_header(input logic [DATA_W-1:0] beat);
		logic [15:0] fld [0:2];
		logic [3:0] idx;
		logic [1:0] d;
		fld[0] = beat[47:32];
		fld[1] = beat[31:16];
		fld[2] = beat[15:0];
		idx = beat[54:51]; // vlan low bits
		for (int k = 0; k < 4; k++) begin
			d = ref_dst[k][idx];
			if (d != DST_NONE) begin
				case (ref_op[k][idx])
					OP_ADD: fld[d] = fld[d] + ref_operand[k][idx];
					OP_SET: fld[d] = ref_operand[k][idx];
					OP_XOR: fld[d] = fld[d] ^ ref_operand[k][idx];
					default: fld[d] = fld[d];
				endcase
			end
		end
		return {beat[63:48], fld[0], fld[1], fld[2]};
	endfunction

	task clear_model;
		for (int k = 0; k < 4; k++) begin
			for (int i = 0; i < 16; i++) begin
				ref_op[k][i] = OP_NOP;
				ref_dst[k][i] = DST_NONE;
				ref_operand[k][i] = 16'h0000;
			end
		end
	endtask

	// called 2 ns after an edge, returns 2 ns after the transfer edge
	task send_beat(input logic [DATA_W-1:0] data, input logic [KEEP_W-1:0] keep,
			input logic last);
		s_axis_tdata = data;
		s_axis_tkeep = keep;
		s_axis_tlast = last;
		s_axis_tvalid = 1'b1;
		while (!s_axis_tready) begin
			@(posedge clk);
			#2;
		end
		@(posedge clk);
		#2;
		s_axis_tvalid = 1'b0;
		beats_sent++;
	endtask

	task send_data(input logic [11:0] vlan, input logic expected);
		int len;
		logic [DATA_W-1:0] beat;
		logic [KEEP_W-1:0] keep;
		logic dropped;
		len = $urandom_range(1, 6);
		dropped = vlan_drop_flags[vlan[4:0]];
		for (int b = 0; b < len; b++) begin
			beat = {$urandom, $urandom};
			keep = KEEP_W'($urandom);
			if (b == 0)
				beat[63:51] = {1'b0, vlan}; // data kind
			if (expected && !dropped) begin
				exp_data.push_back(b == 0 ? expect_header(beat) : beat);
				exp_keep.push_back(keep);
				exp_last.push_back(b == len - 1);
			end
			send_beat(beat, keep, b == len - 1);
		end
	endtask

	task wait_drain;
		while (exp_data.size() != out_count)
			@(posedge clk);
		repeat (4) @(posedge clk);
		#2;
	endtask

	task send_ctrl(input logic [1:0] stage, input logic [3:0] idx, input logic [1:0] op,
			input logic [1:0] dst, input logic [15:0] operand);
		int len;
		logic [DATA_W-1:0] beat;
		wait_drain; // no data phv may see a half updated chain
		len = $urandom_range(1, 3);
		beat = {1'b1, stage, idx, op, dst, operand, 37'($urandom)};
		for (int b = 0; b < len; b++) begin
			if (b > 0)
				beat = {$urandom, $urandom}; // trailing beats are discarded
			send_beat(beat, KEEP_W'($urandom), b == len - 1);
		end
		ref_op[stage][idx] = op;
		ref_dst[stage][idx] = dst;
		ref_operand[stage][idx] = operand;
		exp_token = exp_token + 32'd1;
		repeat (5) @(posedge clk);
		#2;
		assert (ctrl_token == exp_token) else begin
			check_errors++;
			$display("** Error at %0t: ctrl_token %0d, expected %0d", $time, ctrl_token,
				exp_token);
		end
	endtask

	initial begin
		m_axis_tready = 1'b1;
		forever begin
			@(posedge clk);
			#2;
			case (ready_mode)
				1: m_axis_tready = ($urandom_range(0, 3) != 0);
				2: m_axis_tready = 1'b0;
				default: m_axis_tready = 1'b1;
			endcase
		end
	end

	// the beat seen here transfers on the next rising edge
	always @(negedge clk) begin
		if (aresetn && m_axis_tvalid && m_axis_tready) begin
			assert (out_count < exp_data.size()) else begin
				unexpected_beats++;
				$display("** Error at %0t: beat %h on the output with none expected",
					$time, m_axis_tdata);
			end
			if (out_count < exp_data.size()) begin
				assert (m_axis_tdata === exp_data[out_count]
						&& m_axis_tkeep === exp_keep[out_count]
						&& m_axis_tlast === exp_last[out_count]) else begin
					value_errors++;
					$display("** Error at %0t: got %h %h %b, expected %h %h %b", $time,
						m_axis_tdata, m_axis_tkeep, m_axis_tlast, exp_data[out_count],
						exp_keep[out_count], exp_last[out_count]);
				end
				out_count++;
			end
		end
	end

	hold_check: assert property (@(posedge clk) disable iff (!aresetn)
		m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
			&& $stable(m_axis_tkeep) && $stable(m_axis_tlast))
	else begin
		stall_errors++;
		$display("** Error at %0t: output beat changed while stalled", $time);
	end

	// budget grows with every beat that goes in
	initial begin
		int cycles;
		cycles = 0;
		while (cycles <= 200 + 40 * beats_sent) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycles);
		$display("sim failed");
		$finish;
	end

	initial begin
		int missing;
		void'($urandom(32'hb6e1946e));
		aresetn = 1'b0;
		vlan_drop_flags = 32'd0;
		s_axis_tdata = '0;
		s_axis_tkeep = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
		exp_token = 32'd0;
		clear_model;
		repeat (3) @(posedge clk);
		#2;
		aresetn = 1'b1;

		repeat (8) send_data(12'($urandom), 1'b1); // empty tables

		send_ctrl(2'd1, 4'd3, OP_SET, DST_B, 16'hbeef);
		repeat (6) send_data({8'($urandom), 4'd3}, 1'b1);
		repeat (6) send_data(12'($urandom), 1'b1);

		// one index edited by every stage
		send_ctrl(2'd0, 4'd9, OP_ADD, DST_A, 16'hfff0); // wraps for most values
		send_ctrl(2'd1, 4'd9, OP_XOR, DST_A, 16'h00ff);
		send_ctrl(2'd2, 4'd9, OP_SET, DST_C, 16'h1234);
		send_ctrl(2'd3, 4'd9, OP_ADD, DST_C, 16'h0001);
		send_ctrl(2'd0, 4'd6, OP_XOR, DST_NONE, 16'hffff);
		send_ctrl(2'd2, 4'd6, OP_NOP, DST_B, 16'hffff);
		for (int b = 0; b < 10; b++)
			send_data({8'($urandom), (b % 2 == 1) ? 4'd9 : 4'd6}, 1'b1);
		repeat (4) send_ctrl(2'($urandom), 4'($urandom), 2'($urandom), 2'($urandom),
			16'($urandom));
		repeat (8) send_data(12'($urandom), 1'b1);
		wait_drain;

		vlan_drop_flags = $urandom;
		repeat (12) send_data(12'($urandom), 1'b1);
		wait_drain;

		ready_mode = 1;
		repeat (12) send_data(12'($urandom), 1'b1);
		wait_drain;

		// reset with a beat parked in the output slot
		vlan_drop_flags = 32'd0;
		ready_mode = 2;
		send_data(12'h009, 1'b0);
		while (!m_axis_tvalid) begin
			@(posedge clk);
			#2;
		end
		aresetn = 1'b0;
		repeat (3) @(posedge clk);
		#2;
		aresetn = 1'b1;
		ready_mode = 0;
		clear_model;
		exp_token = 32'd0;
		assert (!m_axis_tvalid && ctrl_token == 32'd0) else begin
			check_errors++;
			$display("** Error at %0t: after reset m_axis_tvalid %b, ctrl_token %0d", $time,
				m_axis_tvalid, ctrl_token);
		end
		send_data(12'h009, 1'b1);
		send_data(12'h003, 1'b1);
		wait_drain;

		missing = exp_data.size() - out_count;
		$display("errors: %0d value, %0d unexpected, %0d stall, %0d check, %0d missing",
			value_errors, unexpected_beats, stall_errors, check_errors, missing);
		if (value_errors + unexpected_beats + stall_errors + check_errors + missing == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/match_action_stage.sv
`timescale 1ns/100ps
`default_nettype none

module match_action_stage #(
	parameter int STAGE_ID = 0
) (
	input wire clk,
	input wire aresetn,
	input wire [rmt_pkg::DATA_W-1:0] phv_in,
	input wire phv_in_valid,
	output logic phv_in_ready,
	output logic [rmt_pkg::DATA_W-1:0] phv_out,
	output logic phv_out_valid,
	input wire phv_out_ready,
	input wire ctrl_valid,
	input wire rmt_pkg::hdr_beat_t ctrl_entry
);
	import rmt_pkg::*;

	logic [ACT_W-1:0] act_table [0:(1<<ACT_IDX_W)-1];
	hdr_beat_t hdr_in;
	hdr_beat_t hdr_new;
	logic [ACT_W-1:0] action;
	logic [1:0] act_op;
	logic [1:0] act_dst;
	logic [FIELD_W-1:0] act_operand;
	logic [FIELD_W-1:0] cur_field;
	logic [FIELD_W-1:0] new_field;
	logic tbl_wr;

	function automatic logic [FIELD_W-1:0] apply_op(
		input logic [1:0] op,
		input logic [FIELD_W-1:0] field,
		input logic [FIELD_W-1:0] operand
	);
		case (op)
			OP_ADD: apply_op = field + operand; // wraps at 16 bits
			OP_SET: apply_op = operand;
			OP_XOR: apply_op = field ^ operand;
			default: apply_op = field;
		endcase
	endfunction

	assign tbl_wr = ctrl_valid && ctrl_entry.ctrl.stage_sel == STAGE_SEL_W'(STAGE_ID);

	// entries go back to nop on reset
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			for (int i = 0; i < (1 << ACT_IDX_W); i++)
				act_table[i] <= {OP_NOP, DST_NONE, {FIELD_W{1'b0}}};
		end else if (tbl_wr) begin
			act_table[ctrl_entry.ctrl.entry_idx] <= {ctrl_entry.ctrl.op,
				ctrl_entry.ctrl.dst_sel, ctrl_entry.ctrl.operand};
		end
	end

	assign hdr_in = phv_in;
	assign action = act_table[hdr_in.data.vlan_id[ACT_IDX_W-1:0]]; // lookup by vlan index
	assign act_op = action[ACT_W-1 -: 2];
	assign act_dst = action[ACT_W-3 -: 2];
	assign act_operand = action[FIELD_W-1:0];

	always_comb begin
		case (act_dst)
			DST_A: cur_field = hdr_in.data.field_a;
			DST_B: cur_field = hdr_in.data.field_b;
			default: cur_field = hdr_in.data.field_c;
		endcase
		new_field = apply_op(act_op, cur_field, act_operand);
		hdr_new = hdr_in;
		case (act_dst)
			DST_A: hdr_new.data.field_a = new_field;
			DST_B: hdr_new.data.field_b = new_field;
			DST_C: hdr_new.data.field_c = new_field;
			default: hdr_new = hdr_in; // no field selected
		endcase
	end

	assign phv_in_ready = !phv_out_valid || phv_out_ready;

	always_ff @(posedge clk) begin
		if (!aresetn)
			phv_out_valid <= 1'b0;
		else if (phv_in_valid && phv_in_ready)
			phv_out_valid <= 1'b1;
		else if (phv_out_ready)
			phv_out_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (phv_in_valid && phv_in_ready)
			phv_out <= hdr_new;
	end

endmodule

`default_nettype wire

//--- source/phv_deparser.sv
`timescale 1ns/100ps
`default_nettype none

module phv_deparser (
	input wire clk,
	input wire aresetn,
	input wire [rmt_pkg::DATA_W+rmt_pkg::KEEP_W:0] pkt_dout,
	input wire pkt_empty,
	output logic pkt_rd_en,
	input wire [rmt_pkg::DATA_W-1:0] phv_dout,
	input wire phv_empty,
	output logic phv_rd_en,
	output logic [rmt_pkg::DATA_W-1:0] m_axis_tdata,
	output logic [rmt_pkg::KEEP_W-1:0] m_axis_tkeep,
	output logic m_axis_tvalid,
	input wire m_axis_tready,
	output logic m_axis_tlast
);
	import rmt_pkg::*;

	logic state;
	logic slot_free;
	hdr_beat_t head_beat;
	hdr_beat_t phv;
	hdr_beat_t merged;
	logic [KEEP_W-1:0] head_keep;
	logic head_last;

	assign head_beat = pkt_dout[DATA_W+KEEP_W -: DATA_W];
	assign head_keep = pkt_dout[KEEP_W:1];
	assign head_last = pkt_dout[0];
	assign phv = phv_dout;
	assign slot_free = !m_axis_tvalid || m_axis_tready;

	// modified fields go back over the original first beat
	always_comb begin
		merged = head_beat;
		merged.data.field_a = phv.data.field_a;
		merged.data.field_b = phv.data.field_b;
		merged.data.field_c = phv.data.field_c;
	end

	always_comb begin
		pkt_rd_en = 1'b0;
		phv_rd_en = 1'b0;
		if (slot_free && !pkt_empty) begin
			if (state == DEP_BODY) begin
				pkt_rd_en = 1'b1;
			end else if (!phv_empty) begin
				pkt_rd_en = 1'b1; // first beat needs its phv too
				phv_rd_en = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= DEP_IDLE;
			m_axis_tvalid <= 1'b0;
		end else if (pkt_rd_en) begin
			m_axis_tvalid <= 1'b1;
			state <= head_last ? DEP_IDLE : DEP_BODY;
		end else if (m_axis_tready) begin
			m_axis_tvalid <= 1'b0;
		end
	end

	// output slot, held while the sink stalls
	always_ff @(posedge clk) begin
		if (pkt_rd_en) begin
			m_axis_tdata <= phv_rd_en ? merged : head_beat;
			m_axis_tkeep <= head_keep;
			m_axis_tlast <= head_last;
		end
	end

endmodule

`default_nettype wire

//--- source/phv_parser.sv
`timescale 1ns/100ps
`default_nettype none

module phv_parser (
	input wire clk,
	input wire aresetn,
	input wire [rmt_pkg::DATA_W-1:0] flt_tdata,
	input wire [rmt_pkg::KEEP_W-1:0] flt_tkeep,
	input wire flt_tvalid,
	input wire flt_tlast,
	output logic flt_tready,
	output logic pkt_wr_en,
	output logic [rmt_pkg::DATA_W+rmt_pkg::KEEP_W:0] pkt_din,
	input wire pkt_full,
	output logic [rmt_pkg::DATA_W-1:0] phv_in,
	output logic phv_in_valid,
	input wire phv_in_ready
);

	logic first_beat;

	// a first beat needs room in the fifo and a free stage 0
	assign flt_tready = !pkt_full && (!first_beat || phv_in_ready);

	assign pkt_wr_en = flt_tvalid && flt_tready;
	assign pkt_din = {flt_tdata, flt_tkeep, flt_tlast}; // last in bit 0

	// header vector is the whole first beat
	assign phv_in = flt_tdata;

	// only offered when the packet fifo takes the beat in the same cycle
	assign phv_in_valid = flt_tvalid && first_beat && !pkt_full;

	always_ff @(posedge clk) begin
		if (!aresetn)
			first_beat <= 1'b1;
		else if (pkt_wr_en)
			first_beat <= flt_tlast; // next beat starts a packet
	end

endmodule

`default_nettype wire

//--- source/pkt_filter.sv
`timescale 1ns/100ps
`default_nettype none

module pkt_filter (
	input wire clk,
	input wire aresetn,
	input wire [31:0] vlan_drop_flags,
	input wire [rmt_pkg::DATA_W-1:0] s_axis_tdata,
	input wire [rmt_pkg::KEEP_W-1:0] s_axis_tkeep,
	input wire s_axis_tvalid,
	output logic s_axis_tready,
	input wire s_axis_tlast,
	output logic [rmt_pkg::DATA_W-1:0] flt_tdata,
	output logic [rmt_pkg::KEEP_W-1:0] flt_tkeep,
	output logic flt_tvalid,
	output logic flt_tlast,
	input wire flt_tready,
	output logic ctrl_valid,
	output rmt_pkg::hdr_beat_t ctrl_entry,
	output logic [31:0] ctrl_token
);
	import rmt_pkg::*;

	hdr_beat_t in_hdr;
	logic first_beat;
	logic [1:0] disp_q; // held for the rest of the packet
	logic [1:0] disp_cur;
	logic accept;
	logic fwd_load;
	logic ctrl_hit;

	assign in_hdr = s_axis_tdata;
	assign s_axis_tready = !flt_tvalid || flt_tready;
	assign accept = s_axis_tvalid && s_axis_tready;
	assign fwd_load = accept && disp_cur == DISP_FWD;
	assign ctrl_hit = accept && first_beat && disp_cur == DISP_CTRL;

	// classify on the first beat, later beats follow it
	always_comb begin
		if (!first_beat)
			disp_cur = disp_q;
		else if (in_hdr.data.kind)
			disp_cur = DISP_CTRL;
		else if (vlan_drop_flags[in_hdr.data.vlan_id[DROP_IDX_W-1:0]])
			disp_cur = DISP_DROP;
		else
			disp_cur = DISP_FWD;
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			first_beat <= 1'b1;
			disp_q <= DISP_FWD;
		end else if (accept) begin
			first_beat <= s_axis_tlast;
			disp_q <= disp_cur;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			flt_tvalid <= 1'b0;
		else if (fwd_load)
			flt_tvalid <= 1'b1;
		else if (flt_tready)
			flt_tvalid <= 1'b0; // drained, nothing new
	end

	always_ff @(posedge clk) begin
		if (fwd_load) begin
			flt_tdata <= s_axis_tdata;
			flt_tkeep <= s_axis_tkeep;
			flt_tlast <= s_axis_tlast;
		end
	end

	// one cycle pulse per accepted control packet
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			ctrl_valid <= 1'b0;
			ctrl_token <= 32'd0;
		end else begin
			ctrl_valid <= ctrl_hit;
			if (ctrl_hit)
				ctrl_token <= ctrl_token + 32'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_hit)
			ctrl_entry <= in_hdr;
	end

endmodule

`default_nettype wire

//--- source/rmt_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module rmt_pipeline (
	input wire clk,
	input wire aresetn,
	input wire [31:0] vlan_drop_flags,
	output logic [31:0] ctrl_token,
	input wire [rmt_pkg::DATA_W-1:0] s_axis_tdata,
	input wire [rmt_pkg::KEEP_W-1:0] s_axis_tkeep,
	input wire s_axis_tvalid,
	output logic s_axis_tready,
	input wire s_axis_tlast,
	output logic [rmt_pkg::DATA_W-1:0] m_axis_tdata,
	output logic [rmt_pkg::KEEP_W-1:0] m_axis_tkeep,
	output logic m_axis_tvalid,
	input wire m_axis_tready,
	output logic m_axis_tlast
);
	import rmt_pkg::*;

	// filter to parser
	logic [DATA_W-1:0] flt_tdata;
	logic [KEEP_W-1:0] flt_tkeep;
	logic flt_tvalid;
	logic flt_tlast;
	logic flt_tready;

	logic ctrl_valid; // broadcast to every stage
	hdr_beat_t ctrl_entry;

	logic pkt_wr_en;
	logic [DATA_W+KEEP_W:0] pkt_din;
	logic [DATA_W+KEEP_W:0] pkt_dout;
	logic pkt_full;
	logic pkt_empty;
	logic pkt_rd_en;

	logic [DATA_W-1:0] phv_dout;
	logic phv_full;
	logic phv_empty;
	logic phv_rd_en;

	// index 0 is the parser output, k+1 is the output of stage k
	logic [DATA_W-1:0] stg_phv [0:NUM_STAGES];
	logic stg_valid [0:NUM_STAGES];
	logic stg_ready [0:NUM_STAGES];

	assign stg_ready[NUM_STAGES] = !phv_full;

	pkt_filter u_filter (
		.clk(clk),
		.aresetn(aresetn),
		.vlan_drop_flags(vlan_drop_flags),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tkeep(s_axis_tkeep),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tready(s_axis_tready),
		.s_axis_tlast(s_axis_tlast),
		.flt_tdata(flt_tdata),
		.flt_tkeep(flt_tkeep),
		.flt_tvalid(flt_tvalid),
		.flt_tlast(flt_tlast),
		.flt_tready(flt_tready),
		.ctrl_valid(ctrl_valid),
		.ctrl_entry(ctrl_entry),
		.ctrl_token(ctrl_token)
	);

	phv_parser u_parser (
		.clk(clk),
		.aresetn(aresetn),
		.flt_tdata(flt_tdata),
		.flt_tkeep(flt_tkeep),
		.flt_tvalid(flt_tvalid),
		.flt_tlast(flt_tlast),
		.flt_tready(flt_tready),
		.pkt_wr_en(pkt_wr_en),
		.pkt_din(pkt_din),
		.pkt_full(pkt_full),
		.phv_in(stg_phv[0]),
		.phv_in_valid(stg_valid[0]),
		.phv_in_ready(stg_ready[0])
	);

	for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
		match_action_stage #(
			.STAGE_ID(k)
		) u_stage (
			.clk(clk),
			.aresetn(aresetn),
			.phv_in(stg_phv[k]),
			.phv_in_valid(stg_valid[k]),
			.phv_in_ready(stg_ready[k]),
			.phv_out(stg_phv[k+1]),
			.phv_out_valid(stg_valid[k+1]),
			.phv_out_ready(stg_ready[k+1]),
			.ctrl_valid(ctrl_valid),
			.ctrl_entry(ctrl_entry)
		);
	end

	sync_fifo #(
		.WIDTH(DATA_W + KEEP_W + 1),
		.DEPTH_BITS(PKT_FIFO_DEPTH_BITS)
	) pkt_fifo (
		.clk(clk),
		.aresetn(aresetn),
		.din(pkt_din),
		.wr_en(pkt_wr_en),
		.rd_en(pkt_rd_en),
		.dout(pkt_dout),
		.full(pkt_full),
		.empty(pkt_empty)
	);

	sync_fifo #(
		.WIDTH(DATA_W),
		.DEPTH_BITS(PHV_FIFO_DEPTH_BITS)
	) phv_fifo (
		.clk(clk),
		.aresetn(aresetn),
		.din(stg_phv[NUM_STAGES]),
		.wr_en(stg_valid[NUM_STAGES]), // fifo ignores it while full
		.rd_en(phv_rd_en),
		.dout(phv_dout),
		.full(phv_full),
		.empty(phv_empty)
	);

	phv_deparser u_deparser (
		.clk(clk),
		.aresetn(aresetn),
		.pkt_dout(pkt_dout),
		.pkt_empty(pkt_empty),
		.pkt_rd_en(pkt_rd_en),
		.phv_dout(phv_dout),
		.phv_empty(phv_empty),
		.phv_rd_en(phv_rd_en),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tkeep(m_axis_tkeep),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready),
		.m_axis_tlast(m_axis_tlast)
	);

endmodule

`default_nettype wire

//--- source/rmt_pkg.sv
`default_nettype none

package rmt_pkg;

	localparam int DATA_W = 64; // stream beat, also the phv
	localparam int KEEP_W = DATA_W / 8;
	localparam int VLAN_W = 12;
	localparam int FIELD_W = 16;
	localparam int NUM_STAGES = 4;
	localparam int STAGE_SEL_W = 2;
	localparam int ACT_IDX_W = 4; // 16 table entries
	localparam int ACT_W = 20; // op, dst, operand
	localparam int DROP_IDX_W = 5; // vlan low bits into vlan_drop_flags
	localparam int PKT_FIFO_DEPTH_BITS = 4;
	localparam int PHV_FIFO_DEPTH_BITS = 3;

	// action opcodes
	localparam logic [1:0] OP_NOP = 2'd0;
	localparam logic [1:0] OP_ADD = 2'd1; // modulo 2^16
	localparam logic [1:0] OP_SET = 2'd2;
	localparam logic [1:0] OP_XOR = 2'd3;

	// field selects
	localparam logic [1:0] DST_A = 2'd0;
	localparam logic [1:0] DST_B = 2'd1;
	localparam logic [1:0] DST_C = 2'd2;
	localparam logic [1:0] DST_NONE = 2'd3;

	// what the filter does with the current packet
	localparam logic [1:0] DISP_FWD = 2'd0;
	localparam logic [1:0] DISP_DROP = 2'd1;
	localparam logic [1:0] DISP_CTRL = 2'd2;

	localparam logic DEP_IDLE = 1'b0; // waiting for a first beat
	localparam logic DEP_BODY = 1'b1;

	// first beat of a packet, bit 63 tells the two views apart
	typedef union packed {
		struct packed {
			logic kind; // 0 for data
			logic [VLAN_W-1:0] vlan_id;
			logic [2:0] pad;
			logic [FIELD_W-1:0] field_a;
			logic [FIELD_W-1:0] field_b;
			logic [FIELD_W-1:0] field_c;
		} data;
		struct packed {
			logic kind; // 1 for control
			logic [STAGE_SEL_W-1:0] stage_sel;
			logic [ACT_IDX_W-1:0] entry_idx;
			logic [1:0] op;
			logic [1:0] dst_sel;
			logic [FIELD_W-1:0] operand;
			logic [36:0] pad;
		} ctrl;
	} hdr_beat_t;

endpackage

`default_nettype wire

//--- source/sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 64,
	parameter int DEPTH_BITS = 4
) (
	input wire clk,
	input wire aresetn,
	input wire [WIDTH-1:0] din,
	input wire wr_en,
	input wire rd_en,
	output logic [WIDTH-1:0] dout,
	output logic full,
	output logic empty
);

	logic [WIDTH-1:0] mem [0:(1<<DEPTH_BITS)-1];
	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS-1:0] rd_ptr;
	logic [DEPTH_BITS:0] count;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;
	assign full = count[DEPTH_BITS]; // count reaches 2^DEPTH_BITS only when full
	assign empty = count == '0;
	assign dout = mem[rd_ptr]; // head word falls through

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire
